// ==== logic/core_defines.svh ====
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Datapath and sequence number sizing.
`define DATA_WIDTH 32
`define ROB_SIZE 8
`define SQN_WIDTH 4          // One bit above the ROB index, tells full from empty.

// Pipelined multiplier depth.
`define MUL_LATENCY 3

// Opcode encodings, code 7 executes as add.
`define OP_WIDTH 3
`define OP_ADD 3'd0
`define OP_SUB 3'd1
`define OP_AND 3'd2
`define OP_OR 3'd3
`define OP_XOR 3'd4
`define OP_SLL 3'd5          // Shift amount is srcB[4:0].
`define OP_MUL 3'd6

`endif

// ==== logic/CorePkg.sv ====
`include "core_defines.svh"

package CorePkg;

    // Operand and result value.
    typedef logic [`DATA_WIDTH-1:0] RegT;

    // Sequence number, wraps modulo 16.
    typedef logic [`SQN_WIDTH-1:0] SqN;

    // Reorder buffer slot, the low bits of a sequence number.
    typedef logic [`SQN_WIDTH-2:0] RobIdx;

    typedef logic [`OP_WIDTH-1:0] OpCode;

    // Per-entry life cycle in the reorder buffer.
    typedef enum logic [1:0] {
        RobFree,
        RobPending,          // Allocated, result not back yet.
        RobDone
    } RobState;

endpackage

// ==== logic/UopIf.sv ====
`timescale 1ns/10ps

// Issued micro-op, one per cycle at most, no back-pressure from the units.
interface UopIf;

    logic valid;
    CorePkg::SqN sqN;
    logic isMul;                 // Steers to the multiplier, otherwise ALU.
    CorePkg::OpCode op;
    CorePkg::RegT srcA;
    CorePkg::RegT srcB;

    modport issue (
        output valid,
        output sqN,
        output isMul,
        output op,
        output srcA,
        output srcB
    );

    modport exec (
        input valid,
        input sqN,
        input isMul,
        input op,
        input srcA,
        input srcB
    );

endinterface

// ==== logic/Dispatch.sv ====
`timescale 1ns/10ps
`include "core_defines.svh"

module Dispatch
(
    input  logic           clk,
    input  logic           rstN,

    input  logic           inValid,
    input  CorePkg::OpCode inOp,
    input  CorePkg::RegT   inSrcA,
    input  CorePkg::RegT   inSrcB,
    output logic           inReady,

    input  CorePkg::SqN    commitSqN,
    output logic           allocValid,
    output CorePkg::SqN    allocSqN,

    UopIf.issue            uop
);

    CorePkg::SqN nextSqN;
    CorePkg::SqN outstanding;
    CorePkg::SqN outstandingNext;
    logic accept;

    assign accept = inValid && inReady;

    // Modulo difference stays in 0..8 since at most eight are ever in flight.
    assign outstanding = nextSqN - commitSqN;
    assign outstandingNext = outstanding + CorePkg::SqN'(accept);

    assign allocValid = accept;
    assign allocSqN = nextSqN;

    // Ready uses the commit pointer of this cycle, so a commit frees a slot one cycle late.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            nextSqN <= '0;
            inReady <= 1'b0;
            uop.valid <= 1'b0;
        end else begin
            if (accept) begin
                nextSqN <= nextSqN + 1'b1;
            end
            inReady <= outstandingNext < CorePkg::SqN'(`ROB_SIZE);
            uop.valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            uop.sqN <= nextSqN;
            uop.isMul <= inOp == `OP_MUL;
            uop.op <= inOp;
            uop.srcA <= inSrcA;
            uop.srcB <= inSrcB;
        end
    end

    // The reorder buffer must never be asked for a ninth entry.
    noOverAlloc: assert property (@(posedge clk) disable iff (!rstN)
        accept |-> outstanding != CorePkg::SqN'(`ROB_SIZE));

endmodule

// ==== logic/IntAlu.sv ====
`timescale 1ns/10ps
`include "core_defines.svh"

module IntAlu
(
    input  logic         clk,
    input  logic         rstN,

    UopIf.exec           uop,

    output logic         wbValid,
    output CorePkg::SqN  wbSqN,
    output CorePkg::RegT wbResult
);

    CorePkg::RegT aluResult;
    logic start;

    assign start = uop.valid && !uop.isMul;

    always_comb begin
        case (uop.op)
            `OP_ADD: aluResult = uop.srcA + uop.srcB;
            `OP_SUB: aluResult = uop.srcA - uop.srcB;
            `OP_AND: aluResult = uop.srcA & uop.srcB;
            `OP_OR:  aluResult = uop.srcA | uop.srcB;
            `OP_XOR: aluResult = uop.srcA ^ uop.srcB;
            `OP_SLL: aluResult = uop.srcA << uop.srcB[4:0];
            default: aluResult = uop.srcA + uop.srcB;    // Spare code acts as add.
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wbValid <= 1'b0;
        end else begin
            wbValid <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            wbSqN <= uop.sqN;
            wbResult <= aluResult;
        end
    end

endmodule

// ==== logic/Multiply.sv ====
`timescale 1ns/10ps
`include "core_defines.svh"

module Multiply
(
    input  logic         clk,
    input  logic         rstN,

    UopIf.exec           uop,

    output logic         wbValid,
    output CorePkg::SqN  wbSqN,
    output CorePkg::RegT wbResult
);

    localparam int Stages = `MUL_LATENCY;
    localparam int Half = `DATA_WIDTH / 2;

    logic stageValid [Stages];
    CorePkg::SqN stageSqN [Stages];
    CorePkg::RegT stageProd [Stages];
    CorePkg::RegT partHi;                // Upper half partial product, stage 0.
    logic start;

    assign start = uop.valid && uop.isMul;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < Stages; i++) begin
                stageValid[i] <= 1'b0;
            end
        end else begin
            stageValid[0] <= start;
            for (int i = 1; i < Stages; i++) begin
                stageValid[i] <= stageValid[i-1];
            end
        end
    end

    // Stage 0 splits on srcB halves, stage 1 sums them, the rest only carry.
    always_ff @(posedge clk) begin
        stageSqN[0] <= uop.sqN;
        stageProd[0] <= CorePkg::RegT'(uop.srcA * uop.srcB[Half-1:0]);
        partHi <= CorePkg::RegT'(uop.srcA * uop.srcB[`DATA_WIDTH-1:Half]);
        stageProd[1] <= stageProd[0] + {partHi[Half-1:0], {Half{1'b0}}};
        for (int i = 1; i < Stages; i++) begin
            stageSqN[i] <= stageSqN[i-1];
        end
        for (int i = 2; i < Stages; i++) begin
            stageProd[i] <= stageProd[i-1];
        end
    end

    assign wbValid = stageValid[Stages-1];
    assign wbSqN = stageSqN[Stages-1];
    assign wbResult = stageProd[Stages-1];

endmodule

// ==== logic/ReorderBuffer.sv ====
`timescale 1ns/10ps
`include "core_defines.svh"

module ReorderBuffer
(
    input  logic         clk,
    input  logic         rstN,

    input  logic         allocValid,
    input  CorePkg::SqN  allocSqN,

    input  logic         aluWbValid,
    input  CorePkg::SqN  aluWbSqN,
    input  CorePkg::RegT aluWbResult,

    input  logic         mulWbValid,
    input  CorePkg::SqN  mulWbSqN,
    input  CorePkg::RegT mulWbResult,

    input  logic         comReady,
    output logic         comValid,
    output CorePkg::SqN  comSqN,
    output CorePkg::RegT comResult,
    output CorePkg::SqN  commitSqN
);

    CorePkg::RobState state [`ROB_SIZE];
    CorePkg::RegT result [`ROB_SIZE];

    CorePkg::RobIdx allocIdx;
    CorePkg::RobIdx aluIdx;
    CorePkg::RobIdx mulIdx;
    CorePkg::RobIdx commitIdx;
    CorePkg::RobIdx headIdx;
    CorePkg::SqN headSqN;
    logic comFire;
    logic loadHead;

    assign allocIdx = allocSqN[`SQN_WIDTH-2:0];
    assign aluIdx = aluWbSqN[`SQN_WIDTH-2:0];
    assign mulIdx = mulWbSqN[`SQN_WIDTH-2:0];
    assign commitIdx = commitSqN[`SQN_WIDTH-2:0];

    assign comFire = comValid && comReady;
    assign loadHead = !comValid || comReady;     // Commit register free or draining.

    // Entry to present next, one past the head when it leaves now.
    assign headSqN = comFire ? CorePkg::SqN'(commitSqN + 1'b1) : commitSqN;
    assign headIdx = headSqN[`SQN_WIDTH-2:0];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `ROB_SIZE; i++) begin
                state[i] <= CorePkg::RobFree;
            end
            commitSqN <= '0;
            comValid <= 1'b0;
        end else begin
            if (allocValid) begin
                state[allocIdx] <= CorePkg::RobPending;
            end
            if (aluWbValid) begin
                state[aluIdx] <= CorePkg::RobDone;
            end
            if (mulWbValid) begin
                state[mulIdx] <= CorePkg::RobDone;
            end
            if (comFire) begin
                state[commitIdx] <= CorePkg::RobFree;
                commitSqN <= commitSqN + 1'b1;
            end
            if (loadHead) begin
                comValid <= state[headIdx] == CorePkg::RobDone;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aluWbValid) begin
            result[aluIdx] <= aluWbResult;
        end
        if (mulWbValid) begin
            result[mulIdx] <= mulWbResult;
        end
        if (loadHead) begin
            comSqN <= headSqN;
            comResult <= result[headIdx];
        end
    end

    aluWbPending: assert property (@(posedge clk) disable iff (!rstN)
        aluWbValid |-> state[aluIdx] == CorePkg::RobPending);

    mulWbPending: assert property (@(posedge clk) disable iff (!rstN)
        mulWbValid |-> state[mulIdx] == CorePkg::RobPending);

    comHeadDone: assert property (@(posedge clk) disable iff (!rstN)
        comValid |-> comSqN == commitSqN && state[commitIdx] == CorePkg::RobDone);

endmodule

// ==== logic/Core.sv ====
`timescale 1ns/10ps

module Core
(
    input  logic           clk,
    input  logic           rstN,

    input  logic           inValid,
    input  CorePkg::OpCode inOp,
    input  CorePkg::RegT   inSrcA,
    input  CorePkg::RegT   inSrcB,
    output logic           inReady,

    input  logic           comReady,
    output logic           comValid,
    output CorePkg::SqN    comSqN,
    output CorePkg::RegT   comResult
);

    UopIf uopBus();

    logic allocValid;
    CorePkg::SqN allocSqN;
    CorePkg::SqN commitSqN;

    logic aluWbValid;
    CorePkg::SqN aluWbSqN;
    CorePkg::RegT aluWbResult;

    logic mulWbValid;
    CorePkg::SqN mulWbSqN;
    CorePkg::RegT mulWbResult;

    Dispatch dispatch
    (
        .clk(clk),
        .rstN(rstN),
        .inValid(inValid),
        .inOp(inOp),
        .inSrcA(inSrcA),
        .inSrcB(inSrcB),
        .inReady(inReady),
        .commitSqN(commitSqN),
        .allocValid(allocValid),
        .allocSqN(allocSqN),
        .uop(uopBus.issue)
    );

    IntAlu intAlu
    (
        .clk(clk),
        .rstN(rstN),
        .uop(uopBus.exec),
        .wbValid(aluWbValid),
        .wbSqN(aluWbSqN),
        .wbResult(aluWbResult)
    );

    Multiply mul
    (
        .clk(clk),
        .rstN(rstN),
        .uop(uopBus.exec),
        .wbValid(mulWbValid),
        .wbSqN(mulWbSqN),
        .wbResult(mulWbResult)
    );

    ReorderBuffer rob
    (
        .clk(clk),
        .rstN(rstN),
        .allocValid(allocValid),
        .allocSqN(allocSqN),
        .aluWbValid(aluWbValid),
        .aluWbSqN(aluWbSqN),
        .aluWbResult(aluWbResult),
        .mulWbValid(mulWbValid),
        .mulWbSqN(mulWbSqN),
        .mulWbResult(mulWbResult),
        .comReady(comReady),
        .comValid(comValid),
        .comSqN(comSqN),
        .comResult(comResult),
        .commitSqN(commitSqN)
    );

endmodule

// ==== sim/CoreTb.sv ====
`timescale 1ns/10ps
`include "core_defines.svh"

module CoreTb;

    localparam int Seed = 79674;
    localparam int NumOps = 300;
    localparam int StallCycles = 40;
    localparam int TotalUops = 3 * NumOps + `ROB_SIZE;
    localparam int CycleLimit = 20 * TotalUops + 200;

    logic clk;
    logic rstN;
    logic inValid;
    CorePkg::OpCode inOp;
    CorePkg::RegT inSrcA;
    CorePkg::RegT inSrcB;
    logic inReady;
    logic comReady;
    logic comValid;
    CorePkg::SqN comSqN;
    CorePkg::RegT comResult;

    CorePkg::RegT expResults [$];
    CorePkg::SqN expSqNs [$];
    CorePkg::SqN nextExpSqN;
    int acceptCount;
    int commitCount;
    int cycleCount;
    int commitMode;                      // 0 always ready, 1 random, 2 held low.
    string testName;
    logic sawFirstEdge;
    logic sawCommit;
    logic wasStalled;
    CorePkg::SqN heldSqN;
    CorePkg::RegT heldResult;

    Core dut (
        .clk(clk),
        .rstN(rstN),
        .inValid(inValid),
        .inOp(inOp),
        .inSrcA(inSrcA),
        .inSrcB(inSrcB),
        .inReady(inReady),
        .comReady(comReady),
        .comValid(comValid),
        .comSqN(comSqN),
        .comResult(comResult)
    );

    always #5 clk = ~clk;

    // Reference result from the opcode table, spare code 7 adds.
    function automatic CorePkg::RegT expectResult(input CorePkg::OpCode op,
                                                  input CorePkg::RegT a, input CorePkg::RegT b);
        case (op)
            `OP_SUB: return a - b;
            `OP_AND: return a & b;
            `OP_OR:  return a | b;
            `OP_XOR: return a ^ b;
            `OP_SLL: return a << b[4:0];
            `OP_MUL: return a * b;       // Low word of the product.
            default: return a + b;
        endcase
    endfunction

    task automatic reportFailure(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            reportFailure($sformatf("MISMATCH %s %s expected 0x%08h actual 0x%08h",
                                    testName, name, expected, actual));
        end
    endtask

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= CycleLimit) begin
            reportFailure($sformatf("Timeout, the run did not finish within %0d cycles",
                                    CycleLimit));
        end
        if (!rstN) begin
            checkValue("comValid in reset", 32'd0, 32'(comValid));
        end else begin
            if (!sawFirstEdge) begin
                checkValue("comValid after reset", 32'd0, 32'(comValid));
                sawFirstEdge = 1'b1;
            end
            if (wasStalled) begin
                checkValue("stalled comValid", 32'd1, 32'(comValid));
                checkValue("stalled comSqN", 32'(heldSqN), 32'(comSqN));
                checkValue("stalled comResult", heldResult, comResult);
            end
            wasStalled = comValid && !comReady;
            heldSqN = comSqN;
            heldResult = comResult;
            if (inValid && inReady) begin
                expResults.push_back(expectResult(inOp, inSrcA, inSrcB));
                expSqNs.push_back(nextExpSqN);
                nextExpSqN = nextExpSqN + 1'b1;
                acceptCount++;
            end
            if (comValid && comReady) begin
                if (expResults.size() == 0) begin
                    reportFailure("A commit arrived with no micro-op outstanding");
                end
                if (!sawCommit) begin
                    checkValue("first comSqN", 32'd0, 32'(comSqN));
                    sawCommit = 1'b1;
                end
                checkValue("comSqN", 32'(expSqNs.pop_front()), 32'(comSqN));
                checkValue("comResult", expResults.pop_front(), comResult);
                commitCount++;
            end
            if (acceptCount - commitCount > `ROB_SIZE) begin
                reportFailure("More than eight micro-ops were accepted ahead of commit");
            end
        end
    end

    always @(negedge clk) begin
        case (commitMode)
            0: comReady = 1'b1;
            1: comReady = $urandom_range(99) < 30;   // About 30 % ready.
            default: comReady = 1'b0;
        endcase
    end

    // Mode changes at a rising edge so the next falling edge sees it.
    task automatic setCommitMode(input int mode);
        @(posedge clk);
        commitMode = mode;
        @(negedge clk);
    endtask

    task automatic driveRandomUop(input logic allowMul);
        CorePkg::OpCode op;
        op = CorePkg::OpCode'($urandom_range(7));
        if (op == `OP_MUL) begin
            op = 3'd7;
        end
        if (allowMul && $urandom_range(2) == 0) begin
            op = `OP_MUL;
        end
        inValid = 1'b1;
        inOp = op;
        inSrcA = $urandom();
        inSrcB = $urandom();
    endtask

    task automatic sendUop(input logic allowMul);
        logic taken;
        driveRandomUop(allowMul);
        taken = 1'b0;
        while (!taken) begin
            @(posedge clk);
            taken = inReady;
            @(negedge clk);
        end
        inValid = 1'b0;
    endtask

    // Once everything has committed the buffer is empty and dispatch is open.
    task automatic waitDrain();
        while (expResults.size() != 0) begin
            @(negedge clk);
        end
        checkValue("drained comValid", 32'd0, 32'(comValid));
        checkValue("drained inReady", 32'd1, 32'(inReady));
    endtask

    task automatic runStream(input string name, input logic allowMul, input int mode);
        testName = name;
        setCommitMode(mode);
        for (int i = 0; i < NumOps; i++) begin
            if ($urandom_range(4) == 0) begin
                @(negedge clk);          // Idle bubble on the input.
            end
            sendUop(allowMul);
        end
        setCommitMode(0);
        waitDrain();
    endtask

    task automatic runFullStall();
        logic taken;
        testName = "fullStall";
        setCommitMode(2);
        driveRandomUop(1'b1);
        for (int c = 0; c < StallCycles; c++) begin
            @(posedge clk);
            taken = inReady;
            @(negedge clk);
            if (taken) begin
                driveRandomUop(1'b1);
            end
        end
        inValid = 1'b0;
        checkValue("outstanding at stall", `ROB_SIZE, 32'(acceptCount - commitCount));
        setCommitMode(0);
        waitDrain();
    endtask

    initial begin
        void'($urandom(Seed));
        clk = 1'b0;
        rstN = 1'b0;
        inValid = 1'b0;
        inOp = '0;
        inSrcA = '0;
        inSrcB = '0;
        comReady = 1'b1;
        commitMode = 0;
        testName = "reset";
        nextExpSqN = '0;
        acceptCount = 0;
        commitCount = 0;
        cycleCount = 0;
        sawFirstEdge = 1'b0;
        sawCommit = 1'b0;
        wasStalled = 1'b0;
        repeat (16) @(negedge clk);
        rstN = 1'b1;
        runStream("aluOps", 1'b0, 0);
        runStream("mixed", 1'b1, 0);
        runStream("backPressure", 1'b1, 1);
        runFullStall();
        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+logic
logic/CorePkg.sv
logic/UopIf.sv
logic/Dispatch.sv
logic/IntAlu.sv
logic/Multiply.sv
logic/ReorderBuffer.sv
logic/Core.sv
sim/CoreTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log for the fail message.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module CoreTb \
    -o VCoreTb > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/VCoreTb > sim.log 2>&1
grep -q "TEST FAIL" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
exit 0
